// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_rocc_dma
FILELIST = sources.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: burst_dma_engine.sv
// burst engine that moves words between data memory and the local buffer, one burst per start pulse
module burst_dma_engine
  import rocc_dma_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       start_read,
  input  logic       start_write,
  input  logic       long_burst,
  input  addr_t      base_addr,
  output logic       busy,
  output logic       interrupt,
  output logic       mem_req_valid,
  input  logic       mem_req_ready,
  output addr_t      mem_req_addr,
  output tag_t       mem_req_tag,
  output mem_cmd_t   mem_req_cmd,
  output logic [1:0] mem_req_size,
  input  logic       mem_resp_valid,
  output logic       buf_wr_en,
  output logic       buf_rd_en,
  output buf_idx_t   buf_idx
);

  dma_state_t state;
  buf_idx_t   req_cnt;
  buf_idx_t   resp_cnt;
  buf_idx_t   last_idx;
  addr_t      addr_q;
  tag_t       tag_q;
  tag_t       next_tag;
  mem_cmd_t   cmd_q;
  logic       req_valid_q;
  logic       req_fire;
  logic       last_req;
  logic       last_resp;

  assign last_idx  = long_burst ? buf_idx_t'(BURST_LONG - 1) : buf_idx_t'(BURST_SHORT - 1);
  assign req_fire  = req_valid_q && mem_req_ready;
  assign last_req  = (req_cnt == last_idx);
  assign last_resp = (resp_cnt == last_idx);
  assign next_tag  = (tag_q == TAG_LAST) ? '0 : tag_q + 1'b1;

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state       <= dma_idle;
      req_valid_q <= 1'b0;
      req_cnt     <= '0;
      resp_cnt    <= '0;
      tag_q       <= '0;
    end
    else
    begin
      case (state)
        dma_idle:
        begin
          if (start_read)
          begin
            state       <= dma_read;
            req_valid_q <= 1'b1;
            req_cnt     <= '0;
            resp_cnt    <= '0;
            tag_q       <= next_tag;
          end
          else if (start_write)
          begin
            state   <= dma_write_prime;
            req_cnt <= '0;
            tag_q   <= next_tag;
          end
        end
        dma_read:
        begin
          // requests run ahead of the responses
          if (req_fire)
          begin
            req_cnt <= req_cnt + 1'b1;
            if (last_req)
            begin
              req_valid_q <= 1'b0;
            end
          end
          if (mem_resp_valid)
          begin
            resp_cnt <= resp_cnt + 1'b1;
            if (last_resp)
            begin
              state <= dma_finish;
            end
          end
        end
        dma_write_prime:
        begin
          // word 0 is on the buffer output from here on
          state       <= dma_write;
          req_valid_q <= 1'b1;
        end
        dma_write:
        begin
          if (req_fire)
          begin
            req_cnt <= req_cnt + 1'b1;
            if (last_req)
            begin
              req_valid_q <= 1'b0;
              state       <= dma_finish;
            end
          end
        end
        dma_finish:
        begin
          state <= dma_idle;
        end
        default:
        begin
          state <= dma_idle;
        end
      endcase
    end
  end

  // request address and command
  always_ff @(posedge clock)
  begin
    if (state == dma_idle && start_read)
    begin
      addr_q <= base_addr;
      cmd_q  <= MEM_CMD_READ;
    end
    else if (state == dma_idle && start_write)
    begin
      addr_q <= base_addr;
      cmd_q  <= MEM_CMD_WRITE;
    end
    else if (req_fire)
    begin
      addr_q <= addr_q + WORD_BYTES;
    end
  end

  // during writes the index runs one word ahead of the presented request
  always_comb
  begin
    buf_wr_en = (state == dma_read) && mem_resp_valid;
    buf_rd_en = (state == dma_write_prime) || ((state == dma_write) && req_fire);
    case (state)
      dma_read:  buf_idx = resp_cnt;
      dma_write: buf_idx = req_cnt + 1'b1;
      default:   buf_idx = req_cnt;
    endcase
  end

  // start pulse covers the cycle before the state leaves idle
  assign busy = start_read || start_write ||
                (state inside {dma_read, dma_write_prime, dma_write});
  assign interrupt = (state == dma_finish);

  assign mem_req_valid = req_valid_q;
  assign mem_req_addr  = addr_q;
  assign mem_req_tag   = tag_q;
  assign mem_req_cmd   = cmd_q;
  assign mem_req_size  = MEM_SIZE_WORD;

  a_req_stable: assert property (
    @(posedge clock) disable iff (reset)
    mem_req_valid && !mem_req_ready |=>
      mem_req_valid && $stable(mem_req_addr) && $stable(mem_req_tag) && $stable(mem_req_cmd)
  );

  a_interrupt_pulse: assert property (
    @(posedge clock) disable iff (reset)
    interrupt |=> !interrupt
  );

endmodule

// File: rocc_cmd_unit.sv
// command decoder of the accelerator, holds the configuration and answers with register responses
module rocc_cmd_unit
  import rocc_dma_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     cmd_valid,
  output logic     cmd_ready,
  input  funct_t   cmd_funct,
  input  opcode_t  cmd_opcode,
  input  reg_idx_t cmd_rd,
  input  logic     cmd_xd,
  input  word_t    cmd_rs1,
  output logic     resp_valid,
  input  logic     resp_ready,
  output reg_idx_t resp_rd,
  output word_t    resp_data,
  input  logic     busy,
  output logic     start_read,
  output logic     start_write,
  output logic     long_burst,
  output addr_t    base_addr
);

  logic  accept;
  logic  is_custom;
  logic  is_read;
  logic  is_write;
  logic  is_config;
  word_t resp_data_next;

  // one command in flight, and none while a burst runs
  assign cmd_ready = !resp_valid && !busy;
  assign accept    = cmd_valid && cmd_ready;

  assign is_custom = (cmd_opcode == CUSTOM_OPCODE);
  assign is_config = is_custom && (cmd_funct == FUNCT_CONFIG);
  assign is_read   = is_custom && (cmd_funct == FUNCT_READ);
  assign is_write  = is_custom && (cmd_funct == FUNCT_WRITE);

  // response word as seen at acceptance
  always_comb
  begin
    resp_data_next = '0;
    if (is_config)
    begin
      resp_data_next = word_t'(cmd_rd);
    end
    else if (is_custom && (cmd_funct == FUNCT_STATUS))
    begin
      resp_data_next = {30'd0, long_burst, busy};
    end
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      start_read  <= 1'b0;
      start_write <= 1'b0;
      long_burst  <= 1'b0;
      resp_valid  <= 1'b0;
    end
    else
    begin
      start_read  <= accept && is_read;
      start_write <= accept && is_write;
      // only the burst-length bit of rs1 is kept
      if (accept && is_config)
      begin
        long_burst <= cmd_rs1[0];
      end
      if (accept && cmd_xd)
      begin
        resp_valid <= 1'b1;
      end
      else if (resp_ready)
      begin
        resp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (accept && (is_read || is_write))
    begin
      base_addr <= addr_t'(cmd_rs1);
    end
    if (accept && cmd_xd)
    begin
      resp_rd   <= cmd_rd;
      resp_data <= resp_data_next;
    end
  end

  a_resp_held: assert property (
    @(posedge clock) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid
  );

endmodule

// File: rocc_dma_pkg.sv
// shared widths, command codes, burst lengths and DMA states, imported by every RTL module
package rocc_dma_pkg;

  // meaningful widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [8:0]  tag_t;
  typedef logic [4:0]  mem_cmd_t;
  typedef logic [6:0]  funct_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [9:0]  buf_idx_t;

  // custom-0 opcode space of the core
  localparam opcode_t CUSTOM_OPCODE = 7'h0b;

  // funct field decode
  localparam funct_t FUNCT_CONFIG = 7'd0;
  localparam funct_t FUNCT_READ   = 7'd1;
  localparam funct_t FUNCT_STATUS = 7'd2;
  localparam funct_t FUNCT_WRITE  = 7'd3;

  // burst lengths in words, the long one also sizes the buffer
  localparam int unsigned BURST_SHORT = 128;
  localparam int unsigned BURST_LONG  = 1024;

  // tag wraps to zero after this value
  localparam tag_t TAG_LAST = 9'd63;

  // memory command codes
  localparam mem_cmd_t MEM_CMD_READ  = 5'd0;
  localparam mem_cmd_t MEM_CMD_WRITE = 5'd1;

  // byte step between consecutive words
  localparam addr_t WORD_BYTES = 32'd4;

  // size code for a 32-bit access
  localparam logic [1:0] MEM_SIZE_WORD = 2'd2;

  // burst engine states
  typedef enum logic [2:0] {
    dma_idle,
    dma_read,
    dma_write_prime,
    dma_write,
    dma_finish
  } dma_state_t;

endpackage

// File: rocc_dma_top.sv
// top of the accelerator slice, attached to the core's command, response and data memory ports
module rocc_dma_top
  import rocc_dma_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       cmd_valid,
  output logic       cmd_ready,
  input  funct_t     cmd_funct,
  input  opcode_t    cmd_opcode,
  input  reg_idx_t   cmd_rd,
  input  logic       cmd_xd,
  input  word_t      cmd_rs1,
  // second source operand, carried by the core but read by no supported funct
  input  word_t      cmd_rs2,
  output logic       resp_valid,
  input  logic       resp_ready,
  output reg_idx_t   resp_rd,
  output word_t      resp_data,
  output logic       mem_req_valid,
  input  logic       mem_req_ready,
  output addr_t      mem_req_addr,
  output tag_t       mem_req_tag,
  output mem_cmd_t   mem_req_cmd,
  output logic [1:0] mem_req_size,
  output word_t      mem_req_data,
  input  logic       mem_resp_valid,
  input  word_t      mem_resp_data,
  output logic       busy,
  output logic       interrupt
);

  logic     start_read;
  logic     start_write;
  logic     long_burst;
  addr_t    base_addr;
  logic     buf_wr_en;
  logic     buf_rd_en;
  buf_idx_t buf_idx;

  rocc_cmd_unit u_cmd_unit (
    .clock       (clock),
    .reset       (reset),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_funct   (cmd_funct),
    .cmd_opcode  (cmd_opcode),
    .cmd_rd      (cmd_rd),
    .cmd_xd      (cmd_xd),
    .cmd_rs1     (cmd_rs1),
    .resp_valid  (resp_valid),
    .resp_ready  (resp_ready),
    .resp_rd     (resp_rd),
    .resp_data   (resp_data),
    .busy        (busy),
    .start_read  (start_read),
    .start_write (start_write),
    .long_burst  (long_burst),
    .base_addr   (base_addr)
  );

  burst_dma_engine u_dma_engine (
    .clock          (clock),
    .reset          (reset),
    .start_read     (start_read),
    .start_write    (start_write),
    .long_burst     (long_burst),
    .base_addr      (base_addr),
    .busy           (busy),
    .interrupt      (interrupt),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_addr   (mem_req_addr),
    .mem_req_tag    (mem_req_tag),
    .mem_req_cmd    (mem_req_cmd),
    .mem_req_size   (mem_req_size),
    .mem_resp_valid (mem_resp_valid),
    .buf_wr_en      (buf_wr_en),
    .buf_rd_en      (buf_rd_en),
    .buf_idx        (buf_idx)
  );

  // read data lands in the buffer, buffer output feeds write data
  word_buffer u_buffer (
    .clock   (clock),
    .wr_en   (buf_wr_en),
    .rd_en   (buf_rd_en),
    .idx     (buf_idx),
    .wr_data (mem_resp_data),
    .rd_data (mem_req_data)
  );

endmodule

// File: sources.f
rocc_dma_pkg.sv
word_buffer.sv
burst_dma_engine.sv
rocc_cmd_unit.sv
rocc_dma_top.sv
tb_mem_model.sv
tb_rocc_dma.sv

// File: tb_mem_model.sv
// data memory model for the testbench, with random request back-pressure and in-order read responses
module tb_mem_model
  import rocc_dma_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        mem_req_valid,
  output logic        mem_req_ready,
  input  addr_t       mem_req_addr,
  input  tag_t        mem_req_tag,
  input  mem_cmd_t    mem_req_cmd,
  input  logic [1:0]  mem_req_size,
  input  word_t       mem_req_data,
  output logic        mem_resp_valid,
  output word_t       mem_resp_data,
  input  logic        interrupt,
  input  addr_t       exp_base,
  input  addr_t       exp_src,
  input  tag_t        exp_tag,
  input  mem_cmd_t    exp_cmd,
  output int unsigned req_count,
  output int unsigned errors
);

  // 16 KB of words, indexed by address bits 13 to 2
  word_t       mem [0:4*BURST_LONG-1];
  word_t       pend_q [$];
  logic        ready_q = 1'b0;
  logic        resp_valid_q = 1'b0;
  word_t       resp_data_q = '0;
  int unsigned gap = 0;
  int unsigned count_q = 0;
  int unsigned err_q = 0;
  logic        fire;

  assign fire           = mem_req_valid && mem_req_ready;
  assign mem_req_ready  = ready_q;
  assign mem_resp_valid = resp_valid_q;
  assign mem_resp_data  = resp_data_q;
  assign req_count      = count_q;
  assign errors         = err_q;

  // every word starts from its own address
  initial
  begin
    for (int i = 0; i < 4 * BURST_LONG; i++)
      mem[i] = (word_t'(i) * WORD_BYTES) ^ 32'h3c5a_0f96;
  end

  always @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      ready_q      <= 1'b0;
      resp_valid_q <= 1'b0;
      gap          <= 0;
      count_q      <= 0;
      pend_q.delete();
    end
    else
    begin
      ready_q <= ($urandom % 4) != 0;
      // request count restarts with every burst
      if (interrupt)
        count_q <= 0;
      else if (fire)
        count_q <= count_q + 1;
      if (fire)
      begin
        if (mem_req_cmd == MEM_CMD_WRITE)
          mem[mem_req_addr[13:2]] <= mem_req_data;
        else
          pend_q.push_back(mem[mem_req_addr[13:2]]);
      end
      // one response per read, in order, with random gaps
      resp_valid_q <= 1'b0;
      if (pend_q.size() > 0)
      begin
        if (gap == 0)
        begin
          resp_valid_q <= 1'b1;
          resp_data_q  <= pend_q.pop_front();
          gap          <= $urandom % 4;
        end
        else
          gap <= gap - 1;
      end
    end
  end

  a_req_sequence: assert property (
    @(posedge clock) disable iff (reset)
    fire |-> mem_req_addr == exp_base + WORD_BYTES * req_count && mem_req_tag == exp_tag &&
             mem_req_cmd == exp_cmd && mem_req_size == MEM_SIZE_WORD
  ) else
  begin
    $display("ERROR %0t: request address, tag, command or size out of sequence", $time);
    err_q = err_q + 1;
  end

  a_req_in_range: assert property (
    @(posedge clock) disable iff (reset)
    fire |-> mem_req_addr[31:14] == '0 && mem_req_addr[1:0] == 2'b00
  ) else
  begin
    $display("ERROR %0t: request address %h outside the model", $time, mem_req_addr);
    err_q = err_q + 1;
  end

  // written words must match the region read before
  a_write_data: assert property (
    @(posedge clock) disable iff (reset)
    fire && mem_req_cmd == MEM_CMD_WRITE |-> mem_req_data == mem[exp_src[13:2] + req_count[11:0]]
  ) else
  begin
    $display("ERROR %0t: write data %h differs from the source word", $time, mem_req_data);
    err_q = err_q + 1;
  end

endmodule

// File: tb_rocc_dma.sv
// testbench top, runs configuration, short and long bursts and the busy lockout against the memory model
module tb_rocc_dma
  import rocc_dma_pkg::*;
();

  logic        clock;
  logic        reset;
  logic        cmd_valid;
  logic        cmd_ready;
  funct_t      cmd_funct;
  opcode_t     cmd_opcode;
  reg_idx_t    cmd_rd;
  logic        cmd_xd;
  word_t       cmd_rs1;
  word_t       cmd_rs2;
  logic        resp_valid;
  logic        resp_ready = 1'b0;
  reg_idx_t    resp_rd;
  word_t       resp_data;
  logic        mem_req_valid;
  logic        mem_req_ready;
  addr_t       mem_req_addr;
  tag_t        mem_req_tag;
  mem_cmd_t    mem_req_cmd;
  logic [1:0]  mem_req_size;
  word_t       mem_req_data;
  logic        mem_resp_valid;
  word_t       mem_resp_data;
  logic        busy;
  logic        interrupt;
  reg_idx_t    exp_rd = '0;
  word_t       exp_resp = '0;
  addr_t       exp_base = '0;
  addr_t       exp_src = '0;
  tag_t        exp_tag = '0;
  mem_cmd_t    exp_cmd = '0;
  int unsigned exp_len = 0;
  int unsigned req_count;
  int unsigned model_errors;
  int unsigned errors = 0;
  int unsigned errors_seen = 0;
  int unsigned passed = 0;
  int unsigned failed = 0;
  int unsigned started = 0;
  int unsigned finished = 0;
  tag_t        last_tag = '0;
  logic        cfg_long = 1'b0;
  addr_t       read_base = '0;

  rocc_dma_top u_rocc_dma_top (
    .clock (clock), .reset (reset),
    .cmd_valid (cmd_valid), .cmd_ready (cmd_ready), .cmd_funct (cmd_funct),
    .cmd_opcode (cmd_opcode), .cmd_rd (cmd_rd), .cmd_xd (cmd_xd),
    .cmd_rs1 (cmd_rs1), .cmd_rs2 (cmd_rs2),
    .resp_valid (resp_valid), .resp_ready (resp_ready), .resp_rd (resp_rd),
    .resp_data (resp_data),
    .mem_req_valid (mem_req_valid), .mem_req_ready (mem_req_ready),
    .mem_req_addr (mem_req_addr), .mem_req_tag (mem_req_tag), .mem_req_cmd (mem_req_cmd),
    .mem_req_size (mem_req_size), .mem_req_data (mem_req_data),
    .mem_resp_valid (mem_resp_valid), .mem_resp_data (mem_resp_data),
    .busy (busy), .interrupt (interrupt)
  );

  tb_mem_model u_mem_model (
    .clock (clock), .reset (reset),
    .mem_req_valid (mem_req_valid), .mem_req_ready (mem_req_ready),
    .mem_req_addr (mem_req_addr), .mem_req_tag (mem_req_tag), .mem_req_cmd (mem_req_cmd),
    .mem_req_size (mem_req_size), .mem_req_data (mem_req_data),
    .mem_resp_valid (mem_resp_valid), .mem_resp_data (mem_resp_data),
    .interrupt (interrupt), .exp_base (exp_base), .exp_src (exp_src),
    .exp_tag (exp_tag), .exp_cmd (exp_cmd),
    .req_count (req_count), .errors (model_errors)
  );

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock)
  begin
    resp_ready <= ($urandom % 2) == 1;
  end

  // transfers accepted against bursts finished
  always @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      started  <= 0;
      finished <= 0;
    end
    else
    begin
      if (cmd_valid && cmd_ready && cmd_opcode == CUSTOM_OPCODE &&
          (cmd_funct == FUNCT_READ || cmd_funct == FUNCT_WRITE))
        started <= started + 1;
      if (interrupt)
        finished <= finished + 1;
    end
  end

  a_reset_quiet: assert property (
    @(posedge clock) $fell(reset) |-> !busy && !interrupt && !mem_req_valid && !resp_valid
  ) else
  begin
    $display("ERROR %0t: status or valid output high after reset", $time);
    errors = errors + 1;
  end

  a_resp_value: assert property (
    @(posedge clock) disable iff (reset)
    resp_valid |-> resp_rd == exp_rd && resp_data == exp_resp
  ) else
  begin
    $display("ERROR %0t: response rd %0d data %h, expected rd %0d data %h",
             $time, resp_rd, resp_data, exp_rd, exp_resp);
    errors = errors + 1;
  end

  a_resp_hold: assert property (
    @(posedge clock) disable iff (reset)
    resp_valid && !resp_ready |=> resp_valid && $stable(resp_rd) && $stable(resp_data)
  ) else
  begin
    $display("ERROR %0t: response changed or dropped before it was taken", $time);
    errors = errors + 1;
  end

  a_irq_on_busy_fall: assert property (
    @(posedge clock) disable iff (reset)
    interrupt == $fell(busy)
  ) else
  begin
    $display("ERROR %0t: interrupt not aligned with busy falling", $time);
    errors = errors + 1;
  end

  a_burst_length: assert property (
    @(posedge clock) disable iff (reset)
    interrupt |-> req_count == exp_len
  ) else
  begin
    $display("ERROR %0t: burst issued %0d requests, expected %0d", $time, req_count, exp_len);
    errors = errors + 1;
  end

  a_busy_blocks_cmd: assert property (
    @(posedge clock) disable iff (reset)
    busy |-> !cmd_ready
  ) else
  begin
    $display("ERROR %0t: command accepted while a burst runs", $time);
    errors = errors + 1;
  end

  a_one_transfer: assert property (
    @(posedge clock) disable iff (reset)
    started <= finished + 1
  ) else
  begin
    $display("ERROR %0t: second transfer started before interrupt", $time);
    errors = errors + 1;
  end

  function automatic tag_t tag_after(input tag_t tag);
    // tags count up and wrap to zero after the last one
    if (tag == TAG_LAST)
      return '0;
    return tag + 1'b1;
  endfunction

  task automatic send_cmd(input funct_t funct, input reg_idx_t rd, input logic xd,
                          input word_t rs1, input word_t resp_word);
    @(posedge clock);
    cmd_valid  <= 1'b1;
    cmd_opcode <= CUSTOM_OPCODE;
    cmd_funct  <= funct;
    cmd_rd     <= rd;
    cmd_xd     <= xd;
    cmd_rs1    <= rs1;
    cmd_rs2    <= $urandom;
    exp_rd     <= rd;
    exp_resp   <= resp_word;
    do
      @(posedge clock);
    while (!cmd_ready);
    cmd_valid <= 1'b0;
    if (funct == FUNCT_CONFIG)
      cfg_long = rs1[0];
    else if (funct == FUNCT_READ || funct == FUNCT_WRITE)
    begin
      last_tag = tag_after(last_tag);
      exp_tag  <= last_tag;
      exp_base <= rs1;
      exp_src  <= read_base;
      exp_cmd  <= (funct == FUNCT_READ) ? MEM_CMD_READ : MEM_CMD_WRITE;
      exp_len  <= cfg_long ? BURST_LONG : BURST_SHORT;
      if (funct == FUNCT_READ)
        read_base = rs1;
    end
    // a response leaves only on a ready cycle
    if (xd)
    begin
      do
        @(posedge clock);
      while (!(resp_valid && resp_ready));
    end
  endtask

  task automatic wait_done();
    do
      @(posedge clock);
    while (!interrupt);
  endtask

  task automatic end_test(input string name);
    int unsigned now_errors;
    // count only after the checks of the last rising edge have run
    @(negedge clock);
    now_errors = errors + model_errors;
    if (now_errors == errors_seen)
    begin
      $display("test %s: passed", name);
      passed = passed + 1;
    end
    else
    begin
      $display("test %s: failed with %0d errors", name, now_errors - errors_seen);
      failed = failed + 1;
    end
    errors_seen = now_errors;
  endtask

  // sources in the lower half of the model, destinations in the upper half
  function automatic addr_t pick_src();
    return addr_t'(($urandom % BURST_LONG) * WORD_BYTES);
  endfunction

  function automatic addr_t pick_dst();
    return addr_t'((2 * BURST_LONG + $urandom % BURST_LONG) * WORD_BYTES);
  endfunction

  initial
  begin
    void'($urandom(32'hebce4b01));
    reset      = 1'b1;
    cmd_valid  = 1'b0;
    cmd_funct  = '0;
    cmd_opcode = '0;
    cmd_rd     = '0;
    cmd_xd     = 1'b0;
    cmd_rs1    = '0;
    cmd_rs2    = '0;
    repeat (16) @(posedge clock);
    reset <= 1'b0;

    send_cmd(FUNCT_CONFIG, 5'd7, 1'b1, 32'd0, 32'd7);
    end_test("reset and configuration");

    send_cmd(FUNCT_READ, 5'd0, 1'b0, pick_src(), 32'd0);
    wait_done();
    end_test("short read");

    send_cmd(FUNCT_WRITE, 5'd0, 1'b0, pick_dst(), 32'd0);
    wait_done();
    end_test("short write");

    send_cmd(FUNCT_CONFIG, 5'd12, 1'b1, 32'd1, 32'd12);
    send_cmd(FUNCT_READ, 5'd0, 1'b0, pick_src(), 32'd0);
    wait_done();
    send_cmd(FUNCT_WRITE, 5'd0, 1'b0, pick_dst(), 32'd0);
    wait_done();
    end_test("long copy");

    // status is idle with the long length set, then the write waits behind the read
    send_cmd(FUNCT_STATUS, 5'd3, 1'b1, 32'd0, {30'd0, cfg_long, 1'b0});
    send_cmd(FUNCT_READ, 5'd0, 1'b0, pick_src(), 32'd0);
    send_cmd(FUNCT_WRITE, 5'd0, 1'b0, pick_dst(), 32'd0);
    wait_done();
    end_test("status and busy lockout");

    $display("tests passed %0d, failed %0d, check errors %0d",
             passed, failed, errors + model_errors);
    if (failed == 0 && errors + model_errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  // limit of 64 cycles per burst word over all tests
  initial
  begin
    repeat (64 * (2 * BURST_SHORT + 4 * BURST_LONG)) @(posedge clock);
    $display("watchdog expired: the bursts did not complete in time");
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: word_buffer.sv
// local 1024-word buffer of the accelerator, filled by read bursts and drained by write bursts
module word_buffer
  import rocc_dma_pkg::*;
(
  input  logic     clock,
  input  logic     wr_en,
  input  logic     rd_en,
  input  buf_idx_t idx,
  input  word_t    wr_data,
  output word_t    rd_data
);

  word_t mem [0:BURST_LONG-1];

  // single shared index, so one access per cycle
  always_ff @(posedge clock)
  begin
    if (wr_en)
    begin
      mem[idx] <= wr_data;
    end
  end

  // read word is held until the next enabled read
  always_ff @(posedge clock)
  begin
    if (rd_en)
    begin
      rd_data <= mem[idx];
    end
  end

  // the engine reads only in write bursts and writes only in read bursts
  a_no_rd_wr_overlap: assert property (
    @(posedge clock) !(wr_en && rd_en)
  );

endmodule
